/* sta_top.f */
+incdir+include
hdl/sta_pkg.sv
hdl/xlate_cfg.sv
hdl/addr_xlate.sv
hdl/ld_vio_check.sv
hdl/sta_fu.sv
hdl/sta_top.sv
testbench/tb_sta_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_sta_top
FILELIST  := sta_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_sta_top.sv */
`include "sta_settings.svh"

module tb_sta_top;
    import sta_pkg::*;

    localparam logic [`STA_XLEN-1:0] OFFSET      = 64'h0000_0000_1000_0000;
    localparam logic [`STA_XLEN-1:0] MMIO_BASE   = 64'h0000_0000_4000_0000;
    localparam logic [`STA_XLEN-1:0] MMIO_LIMIT  = 64'h0000_0000_4001_0000;
    localparam logic [`STA_XLEN-1:0] FAULT_BASE  = 64'h0000_0000_2000_0000;
    localparam logic [`STA_XLEN-1:0] FAULT_LIMIT = 64'h0000_0000_2001_0000;
    localparam logic [`STA_XLEN-1:0] PADDR_LIMIT = 64'h0000_0001_0000_0000;
    localparam int TIMEOUT = 50;

    typedef struct packed {int cyc; logic ok; iq_idx_t iq_idx;} fb_ev_t;
    typedef struct packed {int cyc; sq_wr_t wr;} wr_ev_t;
    typedef struct packed {int cyc; except_t ex;} ex_ev_t;
    typedef struct packed {int cyc; rob_idx_t rob_idx;} fin_ev_t;

    logic clk = 1'b0;
    logic rst;
    logic i_vld;
    exe_info_t i_fu_info;
    logic i_ld_wr;
    lq_idx_t i_ld_idx;
    ld_rec_t i_ld_rec;
    logic i_ld_free;
    lq_idx_t i_ld_free_idx;
    logic i_cfg_wr;
    cfg_sel_e i_cfg_sel;
    logic [`STA_XLEN-1:0] i_cfg_data;
    logic o_issue_success;
    logic o_issue_replay;
    iq_idx_t o_feedback_iq_idx;
    sq_wr_t o_sq_wr;
    logic o_has_except;
    except_t o_except;
    logic o_fu_finished;
    rob_idx_t o_fin_rob_idx;

    int cyc = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed = 0;
    int err_start;
    string test_name;
    exe_info_t iss_q[$];
    exe_info_t sent_info[$];
    int sent_t[$];
    fb_ev_t fb_q[$];
    wr_ev_t wr_q[$];
    ex_ev_t ex_q[$];
    fin_ev_t fin_q[$];

    sta_top i_dut (
        .clk               (clk),
        .rst               (rst),
        .i_vld             (i_vld),
        .i_fu_info         (i_fu_info),
        .i_ld_wr           (i_ld_wr),
        .i_ld_idx          (i_ld_idx),
        .i_ld_rec          (i_ld_rec),
        .i_ld_free         (i_ld_free),
        .i_ld_free_idx     (i_ld_free_idx),
        .i_cfg_wr          (i_cfg_wr),
        .i_cfg_sel         (i_cfg_sel),
        .i_cfg_data        (i_cfg_data),
        .o_issue_success   (o_issue_success),
        .o_issue_replay    (o_issue_replay),
        .o_feedback_iq_idx (o_feedback_iq_idx),
        .o_sq_wr           (o_sq_wr),
        .o_has_except      (o_has_except),
        .o_except          (o_except),
        .o_fu_finished     (o_fu_finished),
        .o_fin_rob_idx     (o_fin_rob_idx)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (o_issue_success || o_issue_replay) begin
                fb_q.push_back('{cyc, o_issue_success, o_feedback_iq_idx});
            end
            if (o_sq_wr.valid) begin
                wr_q.push_back('{cyc, o_sq_wr});
            end
            if (o_has_except) begin
                ex_q.push_back('{cyc, o_except});
            end
            if (o_fu_finished) begin
                fin_q.push_back('{cyc, o_fin_rob_idx});
            end
        end
    end

    function automatic int width_bytes(mic_op_e op);
        case (op)
            mic_sb: return 1;
            mic_sh: return 2;
            mic_sw: return 4;
            default: return 8;
        endcase
    endfunction

    // one bit per written byte, starting at the byte offset
    function automatic logic [7:0] byte_mask(mic_op_e op, logic [2:0] off);
        logic [15:0] ones;
        ones = (16'd1 << width_bytes(op)) - 16'd1;
        return 8'(ones) << off;
    endfunction

    function automatic sq_wr_t exp_sq_wr(exe_info_t s);
        sq_wr_t w;
        w.valid   = 1'b1;
        w.sq_idx  = s.sq_idx;
        w.rob_idx = s.rob_idx;
        w.vaddr   = s.src0 + s.src1;
        w.paddr   = w.vaddr + OFFSET;
        w.mask    = byte_mask(s.mic_op, w.vaddr[2:0]);
        return w;
    endfunction

    function automatic exe_info_t make_store(mic_op_e op, logic [63:0] vaddr, rob_idx_t rob);
        exe_info_t s;
        s.rob_idx = rob;
        s.sq_idx  = sq_idx_t'($urandom);
        s.iq_idx  = iq_idx_t'($urandom);
        s.mic_op  = op;
        s.pc      = {32'h0, $urandom};
        s.src0    = {$urandom, $urandom};
        s.src1    = vaddr - s.src0;
        return s;
    endfunction

    function automatic ld_rec_t make_load(rob_idx_t rob, logic [63:0] paddr, logic [7:0] mask);
        ld_rec_t r;
        r.rob_idx = rob;
        r.paddr   = paddr;
        r.mask    = mask;
        r.pc      = {32'h0, $urandom};
        return r;
    endfunction

    function automatic except_t trap_of(exe_info_t s, trap_e tr);
        except_t e;
        e.rob_idx = s.rob_idx;
        e.trap    = tr;
        e.st_pc   = s.pc;
        e.ld_pc   = '0;
        return e;
    endfunction

    function automatic except_t vio_of(exe_info_t s, ld_rec_t ld);
        except_t e;
        e.rob_idx = ld.rob_idx;
        e.trap    = re_exec;
        e.st_pc   = s.pc;
        e.ld_pc   = ld.pc;
        return e;
    endfunction

    task automatic report_problem(string what);
        $display("%s: %s", test_name, what);
        errors++;
    endtask

    task automatic check_feedback(iq_idx_t exp_iq, logic exp_ok, int exp_cyc, fb_ev_t act);
        checks++;
        if (act.iq_idx !== exp_iq || act.ok !== exp_ok || act.cyc != exp_cyc) begin
            $display("Error: %s feedback expected iq %0d %s at cycle %0d, actual iq %0d %s at cycle %0d",
                test_name, exp_iq, exp_ok ? "success" : "replay", exp_cyc,
                act.iq_idx, act.ok ? "success" : "replay", act.cyc);
            errors++;
        end
    endtask

    task automatic check_sq_wr(sq_wr_t exp, int exp_cyc, wr_ev_t act);
        checks++;
        if (act.wr !== exp || act.cyc != exp_cyc) begin
            $display("Error: %s sq_wr expected %h at cycle %0d, actual %h at cycle %0d",
                test_name, exp, exp_cyc, act.wr, act.cyc);
            errors++;
        end
    endtask

    task automatic check_except(except_t exp, int exp_cyc, ex_ev_t act);
        except_t got;
        checks++;
        got = act.ex;
        // load pc only carries meaning for re_exec
        if (exp.trap != re_exec) begin
            got.ld_pc = exp.ld_pc;
        end
        if (got !== exp || act.cyc != exp_cyc) begin
            $display("Error: %s except expected %h at cycle %0d, actual %h at cycle %0d",
                test_name, exp, exp_cyc, act.ex, act.cyc);
            errors++;
        end
    endtask

    task automatic check_finish(rob_idx_t exp_rob, int exp_cyc, fin_ev_t act);
        checks++;
        if (act.rob_idx !== exp_rob || act.cyc != exp_cyc) begin
            $display("Error: %s finish expected rob %0d at cycle %0d, actual rob %0d at cycle %0d",
                test_name, exp_rob, exp_cyc, act.rob_idx, act.cyc);
            errors++;
        end
    endtask

    task automatic write_cfg(cfg_sel_e sel, logic [63:0] data);
        @(negedge clk);
        i_cfg_wr   = 1'b1;
        i_cfg_sel  = sel;
        i_cfg_data = data;
        @(negedge clk);
        i_cfg_wr = 1'b0;
    endtask

    task automatic write_load(lq_idx_t idx, ld_rec_t rec);
        @(negedge clk);
        i_ld_wr  = 1'b1;
        i_ld_idx = idx;
        i_ld_rec = rec;
        @(negedge clk);
        i_ld_wr = 1'b0;
    endtask

    task automatic free_load(lq_idx_t idx);
        @(negedge clk);
        i_ld_free     = 1'b1;
        i_ld_free_idx = idx;
        @(negedge clk);
        i_ld_free = 1'b0;
    endtask

    // issue the queued stores back to back, then wait for every finish
    task automatic run_stores();
        int waited;
        sent_info.delete();
        sent_t.delete();
        foreach (iss_q[i]) begin
            @(negedge clk);
            i_vld     = 1'b1;
            i_fu_info = iss_q[i];
            sent_info.push_back(iss_q[i]);
            sent_t.push_back(cyc);
        end
        @(negedge clk);
        i_vld = 1'b0;
        iss_q.delete();
        waited = 0;
        while (fin_q.size() < sent_info.size() && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (fin_q.size() < sent_info.size()) begin
            report_problem($sformatf("timeout, only %0d of %0d stores finished",
                fin_q.size(), sent_info.size()));
        end
    endtask

    task automatic check_store(int i, logic replay, logic wr, logic ex, except_t exp_ex);
        exe_info_t s;
        int t;
        s = sent_info[i];
        t = sent_t[i];
        if (fb_q.size() == 0) begin
            report_problem($sformatf("no feedback pulse for store %0d", i));
        end else begin
            check_feedback(s.iq_idx, !replay, t + 2, fb_q.pop_front());
        end
        if (wr && wr_q.size() == 0) begin
            report_problem($sformatf("no store queue write for store %0d", i));
        end else if (wr) begin
            check_sq_wr(exp_sq_wr(s), t + 2, wr_q.pop_front());
        end
        if (ex && ex_q.size() == 0) begin
            report_problem($sformatf("no exception for store %0d", i));
        end else if (ex) begin
            check_except(exp_ex, t + 3, ex_q.pop_front());
        end
        if (fin_q.size() == 0) begin
            report_problem($sformatf("no finish pulse for store %0d", i));
        end else begin
            check_finish(s.rob_idx, t + 4, fin_q.pop_front());
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        err_start = errors;
        fb_q.delete();
        wr_q.delete();
        ex_q.delete();
        fin_q.delete();
    endtask

    task automatic finish_test();
        if (fb_q.size() + wr_q.size() + ex_q.size() + fin_q.size() != 0) begin
            report_problem("unexpected extra output pulses");
        end
        tests++;
        if (errors == err_start) begin
            $display("test %s passed", test_name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", test_name, errors - err_start);
        end
    endtask

    // first touch of a page replays, the repeat writes the store queue
    task automatic addr_and_mask();
        exe_info_t st;
        logic [63:0] va;
        int nb;
        start_test("addr_and_mask");
        for (int op = 0; op < 4; op++) begin
            nb = width_bytes(mic_op_e'(op));
            va = 64'h0100_0000 + 64'(op + 1) * 64'h0010_0000
                + 64'($urandom & 32'h000f_f000) + 64'($urandom & 32'h0000_0ff8)
                + 64'(nb * ($urandom % (8 / nb)));
            st = make_store(mic_op_e'(op), va, rob_idx_t'(op));
            iss_q.push_back(st);
            iss_q.push_back(st);
            run_stores();
            check_store(0, 1'b1, 1'b0, 1'b0, '0);
            check_store(1, 1'b0, 1'b1, 1'b0, '0);
        end
        finish_test();
    endtask

    task automatic misaligned_stores();
        start_test("misaligned_stores");
        iss_q.push_back(make_store(mic_sh, 64'h0180_0041, 6'd3));
        iss_q.push_back(make_store(mic_sw, 64'h0180_0042, 6'd4));
        iss_q.push_back(make_store(mic_sd, 64'h0180_0044, 6'd5));
        run_stores();
        for (int i = 0; i < 3; i++) begin
            check_store(i, 1'b0, 1'b0, 1'b1, trap_of(sent_info[i], store_misaligned));
        end
        finish_test();
    endtask

    task automatic translation_flags();
        exe_info_t mm;
        exe_info_t pf;
        exe_info_t il;
        start_test("translation_flags");
        mm = make_store(mic_sd, MMIO_BASE - OFFSET + 64'h100, 6'd6);
        pf = make_store(mic_sd, FAULT_BASE + 64'h40, 6'd7);
        il = make_store(mic_sd, PADDR_LIMIT - OFFSET + 64'h80, 6'd8);
        iss_q = '{mm, mm, mm, pf, pf, il, il};
        run_stores();
        for (int i = 0; i < 3; i++) begin
            check_store(i, 1'b1, 1'b0, 1'b0, '0);
        end
        check_store(3, 1'b1, 1'b0, 1'b0, '0);
        check_store(4, 1'b0, 1'b0, 1'b1, trap_of(pf, store_page_fault));
        check_store(5, 1'b1, 1'b0, 1'b0, '0);
        check_store(6, 1'b0, 1'b0, 1'b1, trap_of(il, store_fault));
        finish_test();
    endtask

    task automatic load_violation();
        exe_info_t st;
        exe_info_t st_wrap;
        ld_rec_t ld;
        start_test("load_violation");
        // sw at byte 4 covers bytes 4 to 7
        st = make_store(mic_sw, 64'h0200_0104, 6'd10);
        ld = make_load(6'd12, OFFSET + 64'h0200_0105, 8'h20);
        write_load(3'd0, ld);
        iss_q = '{st, st};
        run_stores();
        check_store(0, 1'b1, 1'b0, 1'b0, '0);
        check_store(1, 1'b0, 1'b1, 1'b1, vio_of(st, ld));
        write_load(3'd0, make_load(6'd12, OFFSET + 64'h0200_0100, 8'h0f));
        iss_q.push_back(st);
        run_stores();
        check_store(0, 1'b0, 1'b1, 1'b0, '0);
        write_load(3'd0, make_load(6'd8, OFFSET + 64'h0200_0105, 8'h20));
        iss_q.push_back(st);
        run_stores();
        check_store(0, 1'b0, 1'b1, 1'b0, '0);
        // load allocated after the rob index wrapped
        st_wrap = st;
        st_wrap.rob_idx = 6'b0_11110;
        ld = make_load(6'b1_00010, OFFSET + 64'h0200_0106, 8'h40);
        write_load(3'd5, ld);
        iss_q.push_back(st_wrap);
        run_stores();
        check_store(0, 1'b0, 1'b1, 1'b1, vio_of(st_wrap, ld));
        free_load(3'd5);
        write_load(3'd0, make_load(6'd12, OFFSET + 64'h0200_0105, 8'h20));
        free_load(3'd0);
        iss_q.push_back(st);
        run_stores();
        check_store(0, 1'b0, 1'b1, 1'b0, '0);
        finish_test();
    endtask

    task automatic back_to_back();
        exe_info_t s2;
        ld_rec_t ld;
        start_test("back_to_back");
        ld = make_load(6'd24, OFFSET + 64'h0300_0020, 8'h01);
        write_load(3'd3, ld);
        s2 = make_store(mic_sd, 64'h0300_0020, 6'd22);
        iss_q.push_back(make_store(mic_sd, 64'h0300_0000, 6'd19));
        iss_q.push_back(make_store(mic_sb, 64'h0300_0005, 6'd20));
        iss_q.push_back(make_store(mic_sw, 64'h0300_0012, 6'd21));
        iss_q.push_back(s2);
        iss_q.push_back(make_store(mic_sh, 64'h0300_0046, 6'd23));
        run_stores();
        check_store(0, 1'b1, 1'b0, 1'b0, '0);
        check_store(1, 1'b0, 1'b1, 1'b0, '0);
        check_store(2, 1'b0, 1'b0, 1'b1, trap_of(sent_info[2], store_misaligned));
        check_store(3, 1'b0, 1'b1, 1'b1, vio_of(s2, ld));
        check_store(4, 1'b0, 1'b1, 1'b0, '0);
        free_load(3'd3);
        finish_test();
    endtask

    initial begin
        void'($urandom(32'h002becfa));
        rst           = 1'b1;
        i_vld         = 1'b0;
        i_fu_info     = '0;
        i_ld_wr       = 1'b0;
        i_ld_idx      = '0;
        i_ld_rec      = '0;
        i_ld_free     = 1'b0;
        i_ld_free_idx = '0;
        i_cfg_wr      = 1'b0;
        i_cfg_sel     = cfg_offset;
        i_cfg_data    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        write_cfg(cfg_offset, OFFSET);
        write_cfg(cfg_mmio_base, MMIO_BASE);
        write_cfg(cfg_mmio_limit, MMIO_LIMIT);
        write_cfg(cfg_fault_base, FAULT_BASE);
        write_cfg(cfg_fault_limit, FAULT_LIMIT);
        write_cfg(cfg_paddr_limit, PADDR_LIMIT);
        addr_and_mask();
        misaligned_stores();
        translation_flags();
        load_violation();
        back_to_back();
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/sta_top.sv */
`include "sta_settings.svh"

module sta_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    i_vld,
    input  sta_pkg::exe_info_t      i_fu_info,

    input  logic                    i_ld_wr,
    input  sta_pkg::lq_idx_t        i_ld_idx,
    input  sta_pkg::ld_rec_t        i_ld_rec,
    input  logic                    i_ld_free,
    input  sta_pkg::lq_idx_t        i_ld_free_idx,

    input  logic                    i_cfg_wr,
    input  sta_pkg::cfg_sel_e       i_cfg_sel,
    input  logic [`STA_XLEN-1:0]    i_cfg_data,

    output logic                    o_issue_success,
    output logic                    o_issue_replay,
    output sta_pkg::iq_idx_t        o_feedback_iq_idx,
    output sta_pkg::sq_wr_t         o_sq_wr,
    output logic                    o_has_except,
    output sta_pkg::except_t        o_except,
    output logic                    o_fu_finished,
    output sta_pkg::rob_idx_t       o_fin_rob_idx
);
    import sta_pkg::*;

    logic                   xlate_req;
    logic [`STA_XLEN-1:0]   xlate_vaddr;
    xlate_rsp_t             xlate_rsp;
    cfg_t                   cfg;
    vio_req_t               vio_req;
    vio_rsp_t               vio_rsp;

    sta_fu u_sta_fu (
        .clk               (clk),
        .rst               (rst),
        .i_vld             (i_vld),
        .i_fu_info         (i_fu_info),
        .o_xlate_req       (xlate_req),
        .o_xlate_vaddr     (xlate_vaddr),
        .i_xlate           (xlate_rsp),
        .o_issue_success   (o_issue_success),
        .o_issue_replay    (o_issue_replay),
        .o_feedback_iq_idx (o_feedback_iq_idx),
        .o_sq_wr           (o_sq_wr),
        .o_vio_req         (vio_req),
        .i_vio             (vio_rsp),
        .o_has_except      (o_has_except),
        .o_except          (o_except),
        .o_fu_finished     (o_fu_finished),
        .o_fin_rob_idx     (o_fin_rob_idx)
    );

    addr_xlate u_addr_xlate (
        .clk     (clk),
        .rst     (rst),
        .i_cfg   (cfg),
        .i_req   (xlate_req),
        .i_vaddr (xlate_vaddr),
        .o_rsp   (xlate_rsp)
    );

    xlate_cfg u_xlate_cfg (
        .clk        (clk),
        .rst        (rst),
        .i_cfg_wr   (i_cfg_wr),
        .i_cfg_sel  (i_cfg_sel),
        .i_cfg_data (i_cfg_data),
        .o_cfg      (cfg)
    );

    ld_vio_check u_ld_vio_check (
        .clk           (clk),
        .rst           (rst),
        .i_ld_wr       (i_ld_wr),
        .i_ld_idx      (i_ld_idx),
        .i_ld_rec      (i_ld_rec),
        .i_ld_free     (i_ld_free),
        .i_ld_free_idx (i_ld_free_idx),
        .i_req         (vio_req),
        .o_rsp         (vio_rsp)
    );

endmodule

/* hdl/sta_fu.sv */
`include "sta_settings.svh"

module sta_fu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_vld,
    input  sta_pkg::exe_info_t      i_fu_info,

    output logic                    o_xlate_req,
    output logic [`STA_XLEN-1:0]    o_xlate_vaddr,
    input  sta_pkg::xlate_rsp_t     i_xlate,

    output logic                    o_issue_success,
    output logic                    o_issue_replay,
    output sta_pkg::iq_idx_t        o_feedback_iq_idx,

    output sta_pkg::sq_wr_t         o_sq_wr,

    output sta_pkg::vio_req_t       o_vio_req,
    input  sta_pkg::vio_rsp_t       i_vio,

    output logic                    o_has_except,
    output sta_pkg::except_t        o_except,

    output logic                    o_fu_finished,
    output sta_pkg::rob_idx_t       o_fin_rob_idx
);
    import sta_pkg::*;

    logic                   s0_vld;
    exe_info_t              s0_info;
    logic [`STA_XLEN-1:0]   s0_vaddr;
    logic [7:0]             s0_width_mask;
    logic [2:0]             s0_size_m1;
    logic [7:0]             s0_mask;
    logic                   s0_misaligned;

    logic                   s1_vld;
    exe_info_t              s1_info;
    logic [`STA_XLEN-1:0]   s1_vaddr;
    logic [7:0]             s1_mask;
    logic                   s1_misaligned;
    xlate_rsp_t             s1_xlate;
    logic                   s1_replay;
    logic                   s1_fault;
    logic                   s1_ok;

    logic                   s2_vld;
    exe_info_t              s2_info;
    logic                   s2_fault;
    trap_e                  s2_trap;

    logic                   fin_vld;
    rob_idx_t               fin_rob_idx;

    // stage 0: address, mask, alignment
    always_ff @(posedge clk) begin
        if (rst) begin
            s0_vld <= 1'b0;
        end else begin
            s0_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        s0_info <= i_fu_info;
    end

    assign s0_vaddr = s0_info.src0 + s0_info.src1;

    always_comb begin
        case (s0_info.mic_op)
            mic_sb: begin
                s0_width_mask = 8'b0000_0001;
                s0_size_m1    = 3'd0;
            end
            mic_sh: begin
                s0_width_mask = 8'b0000_0011;
                s0_size_m1    = 3'd1;
            end
            mic_sw: begin
                s0_width_mask = 8'b0000_1111;
                s0_size_m1    = 3'd3;
            end
            default: begin
                s0_width_mask = 8'b1111_1111;
                s0_size_m1    = 3'd7;
            end
        endcase
    end

    assign s0_mask       = s0_width_mask << s0_vaddr[2:0];
    assign s0_misaligned = (s0_vaddr[2:0] & s0_size_m1) != 3'd0;

    // misaligned stores skip translation
    assign o_xlate_req   = s0_vld && !s0_misaligned;
    assign o_xlate_vaddr = s0_vaddr;

    // stage 1: feedback, store queue write, violation request
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld        <= 1'b0;
            s1_misaligned <= 1'b0;
        end else begin
            s1_vld        <= s0_vld;
            s1_misaligned <= s0_misaligned;
        end
    end

    always_ff @(posedge clk) begin
        s1_info  <= s0_info;
        s1_vaddr <= s0_vaddr;
        s1_mask  <= s0_mask;
        s1_xlate <= i_xlate;
    end

    assign s1_replay = s1_xlate.miss || s1_xlate.mmio;
    assign s1_fault  = s1_misaligned || s1_xlate.page_fault || s1_xlate.illegal;
    assign s1_ok     = s1_vld && !s1_replay && !s1_fault;

    assign o_issue_success   = s1_vld && !s1_replay;
    assign o_issue_replay    = s1_vld && s1_replay;
    assign o_feedback_iq_idx = s1_info.iq_idx;

    assign o_sq_wr.valid   = s1_ok;
    assign o_sq_wr.sq_idx  = s1_info.sq_idx;
    assign o_sq_wr.rob_idx = s1_info.rob_idx;
    assign o_sq_wr.vaddr   = s1_vaddr;
    assign o_sq_wr.paddr   = s1_xlate.paddr;
    assign o_sq_wr.mask    = s1_mask;

    assign o_vio_req.valid   = s1_ok;
    assign o_vio_req.rob_idx = s1_info.rob_idx;
    assign o_vio_req.paddr   = s1_xlate.paddr;
    assign o_vio_req.mask    = s1_mask;

    // stage 2: exceptions, vio result arrives here
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_vld   <= 1'b0;
            s2_fault <= 1'b0;
        end else begin
            s2_vld   <= s1_vld;
            s2_fault <= s1_vld && !s1_replay && s1_fault;
        end
    end

    always_ff @(posedge clk) begin
        s2_info <= s1_info;
        if (s1_misaligned) begin
            s2_trap <= store_misaligned;
        end else if (s1_xlate.page_fault) begin
            s2_trap <= store_page_fault;
        end else begin
            s2_trap <= store_fault;
        end
    end

    // own fault beats a load violation
    assign o_has_except     = s2_fault || i_vio.vio;
    assign o_except.rob_idx = s2_fault ? s2_info.rob_idx : i_vio.ld_rob_idx;
    assign o_except.trap    = s2_fault ? s2_trap : re_exec;
    assign o_except.st_pc   = s2_info.pc;
    assign o_except.ld_pc   = i_vio.ld_pc;

    // stage 3: finish
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_vld <= 1'b0;
        end else begin
            fin_vld <= s2_vld;
        end
    end

    always_ff @(posedge clk) begin
        fin_rob_idx <= s2_info.rob_idx;
    end

    assign o_fu_finished = fin_vld;
    assign o_fin_rob_idx = fin_rob_idx;

    // a violation answers a clean store one stage back
    a_vio_from_clean_store: assert property (
        @(posedge clk) disable iff (rst)
        i_vio.vio |-> (s2_vld && !s2_fault)
    );

endmodule

/* hdl/ld_vio_check.sv */
`include "sta_settings.svh"

module ld_vio_check (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_ld_wr,
    input  sta_pkg::lq_idx_t    i_ld_idx,
    input  sta_pkg::ld_rec_t    i_ld_rec,
    input  logic                i_ld_free,
    input  sta_pkg::lq_idx_t    i_ld_free_idx,
    input  sta_pkg::vio_req_t   i_req,
    output sta_pkg::vio_rsp_t   o_rsp
);
    import sta_pkg::*;

    ld_rec_t                    ld_tab [`STA_LQ_DEPTH];
    logic [`STA_LQ_DEPTH-1:0]   ld_vld;
    logic [`STA_LQ_DEPTH-1:0]   match;
    logic                       hit;
    lq_idx_t                    hit_idx;
    logic                       vio_q;
    rob_idx_t                   vio_rob_q;
    logic [`STA_XLEN-1:0]       vio_pc_q;

    // true when a is allocated before b, wrap bit flips each lap
    function automatic logic rob_before(rob_idx_t a, rob_idx_t b);
        if (a[`STA_ROB_W-1] == b[`STA_ROB_W-1]) begin
            return a[`STA_ROB_W-2:0] < b[`STA_ROB_W-2:0];
        end
        return a[`STA_ROB_W-2:0] > b[`STA_ROB_W-2:0];
    endfunction

    // write wins over a free to the same slot
    always_ff @(posedge clk) begin
        if (rst) begin
            ld_vld <= '0;
        end else begin
            if (i_ld_free) begin
                ld_vld[i_ld_free_idx] <= 1'b0;
            end
            if (i_ld_wr) begin
                ld_vld[i_ld_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_ld_wr) begin
            ld_tab[i_ld_idx] <= i_ld_rec;
        end
    end

    // younger load, same dword, overlapping bytes
    always_comb begin
        for (int i = 0; i < `STA_LQ_DEPTH; i++) begin
            match[i] = i_req.valid && ld_vld[i]
                && rob_before(i_req.rob_idx, ld_tab[i].rob_idx)
                && (ld_tab[i].paddr[`STA_XLEN-1:3] == i_req.paddr[`STA_XLEN-1:3])
                && ((ld_tab[i].mask & i_req.mask) != 8'h00);
        end
    end

    // pick the oldest offender
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `STA_LQ_DEPTH; i++) begin
            if (match[i] && (!hit || rob_before(ld_tab[i].rob_idx, ld_tab[hit_idx].rob_idx))) begin
                hit     = 1'b1;
                hit_idx = lq_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vio_q <= 1'b0;
        end else begin
            vio_q <= hit;
        end
    end

    always_ff @(posedge clk) begin
        vio_rob_q <= ld_tab[hit_idx].rob_idx;
        vio_pc_q  <= ld_tab[hit_idx].pc;
    end

    assign o_rsp.vio        = vio_q;
    assign o_rsp.ld_rob_idx = vio_rob_q;
    assign o_rsp.ld_pc      = vio_pc_q;

endmodule

/* hdl/addr_xlate.sv */
`include "sta_settings.svh"

module addr_xlate (
    input  logic                    clk,
    input  logic                    rst,
    input  sta_pkg::cfg_t           i_cfg,
    input  logic                    i_req,
    input  logic [`STA_XLEN-1:0]    i_vaddr,
    output sta_pkg::xlate_rsp_t     o_rsp
);
    import sta_pkg::*;

    localparam int VPN_W = `STA_XLEN - `STA_PAGE_BITS;

    logic               tag_vld;
    logic [VPN_W-1:0]   tag_vpn;
    logic [VPN_W-1:0]   req_vpn;
    logic [`STA_XLEN-1:0] paddr;
    logic               miss;
    logic               in_mmio;
    logic               in_fault;
    logic               over_limit;

    assign req_vpn = i_vaddr[`STA_XLEN-1:`STA_PAGE_BITS];
    assign paddr   = i_vaddr + i_cfg.offset;

    assign miss = i_req && (!tag_vld || (tag_vpn != req_vpn));

    assign in_mmio    = (paddr >= i_cfg.mmio_base) && (paddr < i_cfg.mmio_limit);
    assign in_fault   = (i_vaddr >= i_cfg.fault_base) && (i_vaddr < i_cfg.fault_limit);
    assign over_limit = (i_cfg.paddr_limit != '0) && (paddr >= i_cfg.paddr_limit);

    // range checks only count once the tag hits
    assign o_rsp.paddr      = paddr;
    assign o_rsp.miss       = miss;
    assign o_rsp.mmio       = i_req && !miss && in_mmio;
    assign o_rsp.page_fault = i_req && !miss && in_fault;
    assign o_rsp.illegal    = i_req && !miss && over_limit;

    // one-entry page tag, refilled on a miss
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_vld <= 1'b0;
        end else if (miss) begin
            tag_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            tag_vpn <= req_vpn;
        end
    end

endmodule

/* hdl/xlate_cfg.sv */
`include "sta_settings.svh"

module xlate_cfg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_cfg_wr,
    input  sta_pkg::cfg_sel_e       i_cfg_sel,
    input  logic [`STA_XLEN-1:0]    i_cfg_data,
    output sta_pkg::cfg_t           o_cfg
);
    import sta_pkg::*;

    cfg_t cfg_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (i_cfg_wr) begin
            case (i_cfg_sel)
                cfg_offset:      cfg_q.offset      <= i_cfg_data;
                cfg_mmio_base:   cfg_q.mmio_base   <= i_cfg_data;
                cfg_mmio_limit:  cfg_q.mmio_limit  <= i_cfg_data;
                cfg_fault_base:  cfg_q.fault_base  <= i_cfg_data;
                cfg_fault_limit: cfg_q.fault_limit <= i_cfg_data;
                cfg_paddr_limit: cfg_q.paddr_limit <= i_cfg_data;
                default: begin
                end
            endcase
        end
    end

    assign o_cfg = cfg_q;

    // writes to an unmapped selector would be silently dropped
    a_cfg_sel_known: assert property (
        @(posedge clk) disable iff (rst)
        i_cfg_wr |-> (!$isunknown(i_cfg_sel) && (i_cfg_sel <= cfg_paddr_limit))
    );

endmodule

/* hdl/sta_pkg.sv */
`include "sta_settings.svh"

package sta_pkg;

    typedef enum logic [1:0] {
        mic_sb,
        mic_sh,
        mic_sw,
        mic_sd
    } mic_op_e;

    // riscv cause codes, re_exec is internal
    typedef enum logic [4:0] {
        store_misaligned = 5'd6,
        store_fault      = 5'd7,
        store_page_fault = 5'd15,
        re_exec          = 5'd16
    } trap_e;

    typedef logic [`STA_ROB_W-1:0] rob_idx_t;
    typedef logic [4:0] sq_idx_t;
    typedef logic [3:0] iq_idx_t;
    typedef logic [$clog2(`STA_LQ_DEPTH)-1:0] lq_idx_t;

    typedef struct packed {
        rob_idx_t               rob_idx;
        sq_idx_t                sq_idx;
        iq_idx_t                iq_idx;
        mic_op_e                mic_op;
        logic [`STA_XLEN-1:0]   pc;
        logic [`STA_XLEN-1:0]   src0;
        logic [`STA_XLEN-1:0]   src1;
    } exe_info_t;

    typedef struct packed {
        logic [`STA_XLEN-1:0]   paddr;
        logic                   miss;
        logic                   mmio;
        logic                   page_fault;
        logic                   illegal;
    } xlate_rsp_t;

    typedef struct packed {
        logic                   valid;
        sq_idx_t                sq_idx;
        rob_idx_t               rob_idx;
        logic [`STA_XLEN-1:0]   vaddr;
        logic [`STA_XLEN-1:0]   paddr;
        logic [7:0]             mask;
    } sq_wr_t;

    typedef struct packed {
        logic                   valid;
        rob_idx_t               rob_idx;
        logic [`STA_XLEN-1:0]   paddr;
        logic [7:0]             mask;
    } vio_req_t;

    typedef struct packed {
        logic                   vio;
        rob_idx_t               ld_rob_idx;
        logic [`STA_XLEN-1:0]   ld_pc;
    } vio_rsp_t;

    typedef struct packed {
        rob_idx_t               rob_idx;
        logic [`STA_XLEN-1:0]   paddr;
        logic [7:0]             mask;
        logic [`STA_XLEN-1:0]   pc;
    } ld_rec_t;

    typedef struct packed {
        rob_idx_t               rob_idx;
        trap_e                  trap;
        logic [`STA_XLEN-1:0]   st_pc;
        logic [`STA_XLEN-1:0]   ld_pc;
    } except_t;

    typedef struct packed {
        logic [`STA_XLEN-1:0]   offset;
        logic [`STA_XLEN-1:0]   mmio_base;
        logic [`STA_XLEN-1:0]   mmio_limit;
        logic [`STA_XLEN-1:0]   fault_base;
        logic [`STA_XLEN-1:0]   fault_limit;
        logic [`STA_XLEN-1:0]   paddr_limit;
    } cfg_t;

    typedef enum logic [2:0] {
        cfg_offset,
        cfg_mmio_base,
        cfg_mmio_limit,
        cfg_fault_base,
        cfg_fault_limit,
        cfg_paddr_limit
    } cfg_sel_e;

endpackage

/* include/sta_settings.svh */
`ifndef STA_SETTINGS_SVH
`define STA_SETTINGS_SVH

// address and operand width
`define STA_XLEN 64

// rob index, msb is the wrap bit
`define STA_ROB_W 6

// executed-load table size
`define STA_LQ_DEPTH 8

// page offset bits
`define STA_PAGE_BITS 12

`endif
